//--- files.f
hw/ogbcsr_pkg.sv
hw/block_row_if.sv
hw/block_stage.sv
hw/row_stage.sv
hw/ccl_stage.sv
hw/ogbcsr_decoder.sv
testbench/tb_clock.sv
testbench/ogbcsr_assertions.sv
testbench/tb_ogbcsr_decoder.sv

//--- run.sh
#!/bin/sh
# build and run the decoder simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
    --top-module tb_ogbcsr_decoder --Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1

//--- testbench/tb_ogbcsr_decoder.sv
// OGBCSR decoder testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ogbcsr_decoder;

    import ogbcsr_pkg::*;

    localparam int N_COL = 2;
    // block words per run times 4 bits times 16 cycles, plus 100 per test
    localparam int TIMEOUT_CYCLES = 100 + (1 * 64 + 100) + (4 * 64 + 100)
                                  + (8 * 64 + 100) + (16 * 64 + 100);

    logic                    clk;
    logic                    rst_n;
    logic                    decode_en;
    logic [3:0]              len_block_bank;
    logic [4:0]              len_row_bank [N_COL];
    logic [5:0]              len_ccl_bank [N_COL];
    block_mask_t [N_COL-1:0] block_idx_data;
    logic [3:0]              raddr_block_idx_bank;
    logic                    ren_block_idx_bank;
    row_cnt_t                row_cnt_data [N_COL];
    logic [4:0]              raddr_row_cnt_bank [N_COL];
    logic                    ren_row_cnt_bank [N_COL];
    ccl_idx_t                col_clause_idx_data [N_COL];
    logic [5:0]              raddr_ccl_bank [N_COL];
    logic                    ren_ccl_bank [N_COL];
    logic                    decoder_finish;
    logic                    ccl_valid [N_COL];
    block_code_t             ccl_code [N_COL];
    spad_sel_t               ccl_spad [N_COL];
    ccl_idx_t                col_clause_index [N_COL];

    logic [7:0] block_mem [16];
    row_cnt_t   row_mem [N_COL][32];
    ccl_idx_t   ccl_mem [N_COL][64];
    logic [7:0] exp_mem [N_COL][256];
    logic [7:0] got_mem [N_COL][256];
    int         exp_n [N_COL];
    int         got_n [N_COL];
    int         got_base [N_COL];
    int         blk_reads;
    int         cycles = 0;
    int         errors = 0;

    tb_clock #(.PERIOD_NS(20)) i_tb_clock (.clk(clk));

    ogbcsr_decoder #(
        .DEPTH_BLOCK_BANK (16),
        .DEPTH_ROW_BANK   (32),
        .DEPTH_CCL_BANK   (64),
        .N_PE_COL         (N_COL)
    ) i_ogbcsr_decoder (.*);

    // --------------------------------------------------
    // bank models, one cycle registered read
    // --------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_idx_data <= '0;
            for (int c = 0; c < N_COL; c++) begin
                row_cnt_data[c]        <= '0;
                col_clause_idx_data[c] <= '0;
            end
        end else begin
            if (ren_block_idx_bank)
                block_idx_data <= block_mem[raddr_block_idx_bank];
            for (int c = 0; c < N_COL; c++) begin
                if (ren_row_cnt_bank[c])
                    row_cnt_data[c] <= row_mem[c][raddr_row_cnt_bank[c]];
                if (ren_ccl_bank[c])
                    col_clause_idx_data[c] <= ccl_mem[c][raddr_ccl_bank[c]];
            end
        end
    end

    // monitor samples away from the active edge
    always @(negedge clk) begin
        if (!rst_n) begin
            blk_reads = 0;
            for (int c = 0; c < N_COL; c++)
                got_n[c] = 0;
        end else begin
            if (ren_block_idx_bank)
                blk_reads = blk_reads + 1;
            for (int c = 0; c < N_COL; c++) begin
                if (ccl_valid[c]) begin
                    got_mem[c][got_n[c]] = {ccl_code[c], ccl_spad[c], col_clause_index[c]};
                    got_n[c] = got_n[c] + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("CHECKS FAILED");
            $fatal(1, "timeout after %0d cycles without finishing the tests", cycles);
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic mask_bit(input int w, input int c, input int b);
        logic [7:0] word;
        word = block_mem[w] >> (c * 4 + b);
        return word[0];
    endfunction

    task automatic fill_banks();
        for (int a = 0; a < 16; a++)
            block_mem[a] = '0;
        for (int c = 0; c < N_COL; c++) begin
            for (int a = 0; a < 32; a++)
                row_mem[c][a] = '0;
            for (int a = 0; a < 64; a++)
                ccl_mem[c][a] = ccl_idx_t'(a * 7 + (a >> 5) + c * 3 + 1);
        end
    endtask

    // walk the banks and drive lengths from what the run consumes
    task automatic build_expected(input int words);
        int       rp;
        int       cp;
        row_cnt_t e;
        for (int c = 0; c < N_COL; c++) begin
            rp = 0;
            cp = 0;
            exp_n[c] = 0;
            for (int w = 0; w < words; w++) begin
                for (int b = 0; b < 4; b++) begin
                    if (mask_bit(w, c, b)) begin
                        e = row_mem[c][rp];
                        rp++;
                        for (int i = 0; i < int'(e[2:0]); i++) begin
                            exp_mem[c][exp_n[c]] = {2'(b), 1'b0, ccl_mem[c][cp]};
                            exp_n[c]++;
                            cp++;
                        end
                        for (int i = 0; i < int'(e[5:3]); i++) begin
                            exp_mem[c][exp_n[c]] = {2'(b), 1'b1, ccl_mem[c][cp]};
                            exp_n[c]++;
                            cp++;
                        end
                    end
                end
            end
            len_row_bank[c] = 5'(rp);
            len_ccl_bank[c] = 6'(cp);
        end
        len_block_bank = 4'(words);
    endtask

    task automatic apply_reset();
        rst_n     = 1'b0;
        decode_en = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic mark_stream_start();
        for (int c = 0; c < N_COL; c++)
            got_base[c] = got_n[c];
    endtask

    task automatic run_decode(input int words);
        int start_reads;
        start_reads = blk_reads;
        @(posedge clk);
        #2;
        decode_en = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!decoder_finish);
        check("block reads at decoder_finish", 32'(blk_reads - start_reads), 32'(words));
        #1;
        decode_en = 1'b0;
        repeat (60) @(posedge clk);
        #2;
    endtask

    task automatic compare_streams();
        for (int c = 0; c < N_COL; c++) begin
            check($sformatf("ccl_valid count col %0d", c),
                  32'(got_n[c] - got_base[c]), 32'(exp_n[c]));
            for (int i = 0; i < exp_n[c]; i++)
                check($sformatf("{ccl_code,ccl_spad,col_clause_index} col %0d item %0d", c, i),
                      32'(got_mem[c][got_base[c] + i]), 32'(exp_mem[c][i]));
        end
    endtask

    // after a full run every bank address is back at zero
    task automatic check_addresses_wrapped();
        check("raddr_block_idx_bank", 32'(raddr_block_idx_bank), 32'd0);
        for (int c = 0; c < N_COL; c++) begin
            check($sformatf("raddr_row_cnt_bank[%0d]", c), 32'(raddr_row_cnt_bank[c]), 32'd0);
            check($sformatf("raddr_ccl_bank[%0d]", c), 32'(raddr_ccl_bank[c]), 32'd0);
        end
    endtask

    task automatic decode_and_compare(input int words);
        apply_reset();
        build_expected(words);
        mark_stream_start();
        run_decode(words);
        compare_streams();
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset();
        apply_reset();
        repeat (2) @(posedge clk);
        #2;
        check("ren_block_idx_bank", 32'(ren_block_idx_bank), 32'd0);
        check("decoder_finish", 32'(decoder_finish), 32'd0);
        for (int c = 0; c < N_COL; c++) begin
            check($sformatf("ren_row_cnt_bank[%0d]", c), 32'(ren_row_cnt_bank[c]), 32'd0);
            check($sformatf("ren_ccl_bank[%0d]", c), 32'(ren_ccl_bank[c]), 32'd0);
            check($sformatf("ccl_valid[%0d]", c), 32'(ccl_valid[c]), 32'd0);
        end
    endtask

    task automatic test_single();
        fill_banks();
        // column 0 bit 2, counter 1 = 1, counter 0 = 2
        block_mem[0]  = 8'h04;
        row_mem[0][0] = 6'o12;
        decode_and_compare(1);
        check("ccl_valid count col 0", 32'(got_n[0]), 32'd3);
        check("ccl_valid count col 1", 32'(got_n[1]), 32'd0);
        check("last item col 0", 32'(got_mem[0][2]), 32'({2'd2, 1'b1, ccl_mem[0][2]}));
    endtask

    task automatic test_sparse();
        row_cnt_t rows0 [7];
        row_cnt_t rows1 [6];
        fill_banks();
        block_mem[0] = 8'h0B;
        block_mem[1] = 8'hF0;
        block_mem[2] = 8'h16;
        block_mem[3] = 8'h49;
        rows0 = '{6'o12, 6'o00, 6'o03, 6'o00, 6'o21, 6'o00, 6'o10};
        rows1 = '{6'o00, 6'o11, 6'o00, 6'o02, 6'o30, 6'o00};
        for (int i = 0; i < 7; i++)
            row_mem[0][i] = rows0[i];
        for (int i = 0; i < 6; i++)
            row_mem[1][i] = rows1[i];
        decode_and_compare(4);
    endtask

    task automatic test_random();
        int rp [N_COL];
        int used [N_COL];
        int n0;
        int n1;
        fill_banks();
        for (int c = 0; c < N_COL; c++) begin
            rp[c]   = 0;
            used[c] = 0;
        end
        for (int w = 0; w < 8; w++)
            block_mem[w] = 8'($urandom);
        for (int w = 0; w < 8; w++) begin
            for (int c = 0; c < N_COL; c++) begin
                for (int b = 0; b < 4; b++) begin
                    if (mask_bit(w, c, b)) begin
                        n0 = $urandom % 3;
                        n1 = $urandom % 2;
                        // keep the col/clause bank below one wrap
                        if (used[c] + n0 + n1 > 60) begin
                            n0 = 0;
                            n1 = 0;
                        end
                        used[c] = used[c] + n0 + n1;
                        row_mem[c][rp[c]] = {3'(n1), 3'(n0)};
                        rp[c]++;
                    end
                end
            end
        end
        decode_and_compare(8);
    endtask

    task automatic test_finish_rerun();
        // banks from the random test stay in place
        decode_and_compare(8);
        check_addresses_wrapped();
        mark_stream_start();
        run_decode(8);
        compare_streams();
        check_addresses_wrapped();
    endtask

    initial begin
        void'($urandom(32'h263f));
        rst_n          = 1'b0;
        decode_en      = 1'b0;
        len_block_bank = '0;
        for (int c = 0; c < N_COL; c++) begin
            len_row_bank[c] = '0;
            len_ccl_bank[c] = '0;
        end
        fill_banks();
        test_reset();
        test_single();
        test_sparse();
        test_random();
        test_finish_rerun();
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

`default_nettype wire

//--- testbench/ogbcsr_assertions.sv
// Decoder protocol assertions
`timescale 1ns/1ps
`default_nettype none

module ogbcsr_assertions (
    input logic clk,
    input logic rst_n,
    input logic blk_ren,
    input logic blk_below_len,
    input logic ccl_ren,
    input logic ccl_valid
);

    // block address never runs past its length
    a_read_below_len: assert property (@(posedge clk) disable iff (!rst_n)
        blk_ren |-> blk_below_len)
        else $error("block bank read issued at or past configured length");

    // sram needs a cycle between block reads
    a_read_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        blk_ren |=> !blk_ren)
        else $error("back to back block bank reads");

    a_ccl_align: assert property (@(posedge clk) disable iff (!rst_n)
        ccl_valid == $past(ccl_ren))
        else $error("ccl_valid not aligned to col/clause read");

endmodule

bind block_stage ogbcsr_assertions i_blk_assertions (
    .clk           (clk),
    .rst_n         (rst_n),
    .blk_ren       (ren_block_idx_bank),
    .blk_below_len (raddr_block_idx_bank < len_block_bank),
    .ccl_ren       (1'b0),
    .ccl_valid     (1'b0)
);

bind ccl_stage ogbcsr_assertions i_ccl_assertions (
    .clk           (clk),
    .rst_n         (rst_n),
    .blk_ren       (1'b0),
    .blk_below_len (1'b1),
    .ccl_ren       (ren_ccl_bank),
    .ccl_valid     (ccl_valid)
);

`default_nettype wire

//--- testbench/tb_clock.sv
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- hw/ogbcsr_decoder.sv
// OGBCSR decompression pipeline
`timescale 1ns/1ps
`default_nettype none

module ogbcsr_decoder #(
    parameter int DEPTH_BLOCK_BANK = 16,
    parameter int DEPTH_ROW_BANK   = 32,
    parameter int DEPTH_CCL_BANK   = 64,
    parameter int N_PE_COL         = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   decode_en,

    // --------------------------------------------------
    // configuration
    input  logic [$clog2(DEPTH_BLOCK_BANK)-1:0]    len_block_bank,
    input  logic [$clog2(DEPTH_ROW_BANK)-1:0]      len_row_bank [N_PE_COL],
    input  logic [$clog2(DEPTH_CCL_BANK)-1:0]      len_ccl_bank [N_PE_COL],

    // --------------------------------------------------
    // bank ports
    input  ogbcsr_pkg::block_mask_t [N_PE_COL-1:0] block_idx_data,
    output logic [$clog2(DEPTH_BLOCK_BANK)-1:0]    raddr_block_idx_bank,
    output logic                                   ren_block_idx_bank,
    input  ogbcsr_pkg::row_cnt_t                   row_cnt_data [N_PE_COL],
    output logic [$clog2(DEPTH_ROW_BANK)-1:0]      raddr_row_cnt_bank [N_PE_COL],
    output logic                                   ren_row_cnt_bank [N_PE_COL],
    input  ogbcsr_pkg::ccl_idx_t                   col_clause_idx_data [N_PE_COL],
    output logic [$clog2(DEPTH_CCL_BANK)-1:0]      raddr_ccl_bank [N_PE_COL],
    output logic                                   ren_ccl_bank [N_PE_COL],

    // --------------------------------------------------
    // results
    output logic                                   decoder_finish,
    output logic                                   ccl_valid [N_PE_COL],
    output ogbcsr_pkg::block_code_t                ccl_code [N_PE_COL],
    output ogbcsr_pkg::spad_sel_t                  ccl_spad [N_PE_COL],
    output ogbcsr_pkg::ccl_idx_t                   col_clause_index [N_PE_COL]
);

    block_row_if blk_row [N_PE_COL] ();

    block_stage #(
        .DEPTH_BLOCK_BANK (DEPTH_BLOCK_BANK),
        .N_PE_COL         (N_PE_COL)
    ) i_block_stage (
        .clk                  (clk),
        .rst_n                (rst_n),
        .decode_en            (decode_en),
        .len_block_bank       (len_block_bank),
        .block_idx_data       (block_idx_data),
        .raddr_block_idx_bank (raddr_block_idx_bank),
        .ren_block_idx_bank   (ren_block_idx_bank),
        .decoder_finish       (decoder_finish),
        .blk_if               (blk_row)
    );

    // one row and one col/clause stage per PE column
    for (genvar c = 0; c < N_PE_COL; c++) begin : g_col
        logic                    row_valid;
        ogbcsr_pkg::spad_sel_t   row_spad;
        ogbcsr_pkg::block_code_t row_code;

        row_stage #(
            .DEPTH_ROW_BANK (DEPTH_ROW_BANK)
        ) i_row_stage (
            .clk                (clk),
            .rst_n              (rst_n),
            .len_row_bank       (len_row_bank[c]),
            .row_cnt_data       (row_cnt_data[c]),
            .raddr_row_cnt_bank (raddr_row_cnt_bank[c]),
            .ren_row_cnt_bank   (ren_row_cnt_bank[c]),
            .blk_if             (blk_row[c]),
            .row_valid          (row_valid),
            .row_spad           (row_spad),
            .row_code           (row_code)
        );

        ccl_stage #(
            .DEPTH_CCL_BANK (DEPTH_CCL_BANK)
        ) i_ccl_stage (
            .clk                 (clk),
            .rst_n               (rst_n),
            .len_ccl_bank        (len_ccl_bank[c]),
            .row_valid           (row_valid),
            .row_spad            (row_spad),
            .row_code            (row_code),
            .col_clause_idx_data (col_clause_idx_data[c]),
            .raddr_ccl_bank      (raddr_ccl_bank[c]),
            .ren_ccl_bank        (ren_ccl_bank[c]),
            .ccl_valid           (ccl_valid[c]),
            .ccl_code            (ccl_code[c]),
            .ccl_spad            (ccl_spad[c]),
            .col_clause_index    (col_clause_index[c])
        );
    end

endmodule

`default_nettype wire

//--- hw/ccl_stage.sv
// Col/clause index stage
`timescale 1ns/1ps
`default_nettype none

module ccl_stage #(
    parameter int DEPTH_CCL_BANK = 64
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [$clog2(DEPTH_CCL_BANK)-1:0]   len_ccl_bank,
    input  logic                                row_valid,
    input  ogbcsr_pkg::spad_sel_t               row_spad,
    input  ogbcsr_pkg::block_code_t             row_code,
    input  ogbcsr_pkg::ccl_idx_t                col_clause_idx_data,
    output logic [$clog2(DEPTH_CCL_BANK)-1:0]   raddr_ccl_bank,
    output logic                                ren_ccl_bank,
    output logic                                ccl_valid,
    output ogbcsr_pkg::block_code_t             ccl_code,
    output ogbcsr_pkg::spad_sel_t               ccl_spad,
    output ogbcsr_pkg::ccl_idx_t                col_clause_index
);

    // one read per counted item
    assign ren_ccl_bank = row_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raddr_ccl_bank <= '0;
        end else if (ren_ccl_bank) begin
            raddr_ccl_bank <= raddr_ccl_bank + 1'b1;
        end else if (raddr_ccl_bank == len_ccl_bank) begin
            raddr_ccl_bank <= '0;
        end
    end

    // line up with the index returning from the bank
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ccl_valid <= 1'b0;
        end else begin
            ccl_valid <= row_valid;
        end
    end

    always_ff @(posedge clk) begin
        ccl_code <= row_code;
        ccl_spad <= row_spad;
    end

    assign col_clause_index = col_clause_idx_data;

endmodule

`default_nettype wire

//--- hw/row_stage.sv
// Row count stage
`timescale 1ns/1ps
`default_nettype none

module row_stage #(
    parameter int DEPTH_ROW_BANK = 32
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [$clog2(DEPTH_ROW_BANK)-1:0]   len_row_bank,
    input  ogbcsr_pkg::row_cnt_t                row_cnt_data,
    output logic [$clog2(DEPTH_ROW_BANK)-1:0]   raddr_row_cnt_bank,
    output logic                                ren_row_cnt_bank,
    block_row_if.row                            blk_if,
    output logic                                row_valid,
    output ogbcsr_pkg::spad_sel_t               row_spad,
    output ogbcsr_pkg::block_code_t             row_code
);

    import ogbcsr_pkg::*;

    logic              ren_d1;
    logic              last_taken;
    logic              almost_done;
    logic              near_done;
    ta_cnt_t           cnt0_q;
    ta_cnt_t           cnt1_q;
    ta_cnt_t           cnt0;
    ta_cnt_t           cnt1;
    logic [TA_CNT_W:0] cnt_sum;

    // --------------------------------------------------
    // handshake with block stage
    // --------------------------------------------------
    assign cnt_sum     = {1'b0, cnt0} + {1'b0, cnt1};
    assign almost_done = (cnt_sum <= 1);
    assign near_done   = (cnt_sum <= 2);

    assign blk_if.take      = almost_done;
    assign blk_if.free      = near_done && last_taken;
    assign ren_row_cnt_bank = blk_if.valid && almost_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_taken <= 1'b0;
        end else if (almost_done) begin
            last_taken <= blk_if.last;
        end
    end

    // code of the entry being counted
    always_ff @(posedge clk) begin
        if (ren_row_cnt_bank) begin
            row_code <= blk_if.code;
        end
    end

    // --------------------------------------------------
    // row bank address
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raddr_row_cnt_bank <= '0;
        end else if (ren_row_cnt_bank) begin
            raddr_row_cnt_bank <= raddr_row_cnt_bank + 1'b1;
        end else if (raddr_row_cnt_bank == len_row_bank) begin
            raddr_row_cnt_bank <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ren_d1 <= 1'b0;
        end else begin
            ren_d1 <= ren_row_cnt_bank;
        end
    end

    // --------------------------------------------------
    // automaton counters, spad 0 drains first
    // --------------------------------------------------
    assign cnt0 = ren_d1 ? row_cnt_data[TA_CNT_W-1:0] : cnt0_q;
    assign cnt1 = ren_d1 ? row_cnt_data[ROW_CNT_W-1:TA_CNT_W] : cnt1_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt0_q <= '0;
            cnt1_q <= '0;
        end else begin
            cnt0_q <= (cnt0 != '0) ? cnt0 - 1'b1 : '0;
            cnt1_q <= (cnt0 == '0 && cnt1 != '0) ? cnt1 - 1'b1 : cnt1;
        end
    end

    assign row_valid = (cnt0 != '0) || (cnt1 != '0);
    assign row_spad  = (cnt0 != '0) ? SPAD_0 : SPAD_1;

endmodule

`default_nettype wire

//--- hw/block_stage.sv
// Block index stage
`timescale 1ns/1ps
`default_nettype none

module block_stage #(
    parameter int DEPTH_BLOCK_BANK = 16,
    parameter int N_PE_COL         = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   decode_en,
    input  logic [$clog2(DEPTH_BLOCK_BANK)-1:0]    len_block_bank,
    input  ogbcsr_pkg::block_mask_t [N_PE_COL-1:0] block_idx_data,
    output logic [$clog2(DEPTH_BLOCK_BANK)-1:0]    raddr_block_idx_bank,
    output logic                                   ren_block_idx_bank,
    output logic                                   decoder_finish,
    block_row_if.blk                               blk_if [N_PE_COL]
);

    import ogbcsr_pkg::*;

    logic [N_PE_COL-1:0] col_free;
    logic                wait_sram;
    logic                at_end;

    // --------------------------------------------------
    // block bank address
    // --------------------------------------------------
    assign at_end = (raddr_block_idx_bank == len_block_bank);

    // new word only once every column has drained its last bit
    assign ren_block_idx_bank = decode_en && !wait_sram && (&col_free) && !at_end;
    assign decoder_finish     = decode_en && at_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raddr_block_idx_bank <= '0;
        end else if (ren_block_idx_bank) begin
            raddr_block_idx_bank <= raddr_block_idx_bank + 1'b1;
        end else if (at_end) begin
            // wrap so the same map can be decoded again
            raddr_block_idx_bank <= '0;
        end
    end

    // data is valid in the cycle after the read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_sram <= 1'b0;
        end else begin
            wait_sram <= ren_block_idx_bank;
        end
    end

    // --------------------------------------------------
    // per column mask walking
    // --------------------------------------------------
    for (genvar c = 0; c < N_PE_COL; c++) begin : g_col
        block_mask_t mask_q;
        block_mask_t mask_live;
        block_mask_t mask_clr;
        block_code_t low_code;

        // fresh bank word bypasses the register
        assign mask_live = wait_sram ? block_idx_data[c] : mask_q;

        // lowest set bit first
        always_comb begin
            casez (mask_live)
                4'b???1: low_code = CODE_BIT0;
                4'b??10: low_code = CODE_BIT1;
                4'b?100: low_code = CODE_BIT2;
                4'b1000: low_code = CODE_BIT3;
                default: low_code = CODE_BIT0;
            endcase
        end

        assign mask_clr = blk_if[c].take ? block_mask_t'(4'b0001 << low_code) : '0;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                mask_q <= '0;
            end else begin
                mask_q <= mask_live & ~mask_clr;
            end
        end

        assign blk_if[c].valid = |mask_live;
        assign blk_if[c].code  = low_code;
        // at most one bit left
        assign blk_if[c].last  = ((mask_live & (mask_live - 1'b1)) == '0);
        assign col_free[c]     = blk_if[c].free;
    end

endmodule

`default_nettype wire

//--- hw/block_row_if.sv
// Block to row stage handshake
`timescale 1ns/1ps
`default_nettype none

interface block_row_if;

    import ogbcsr_pkg::*;

    // block stage side
    logic        valid;
    block_code_t code;
    logic        last;

    // row stage side
    logic        take;
    logic        free;

    modport blk (
        output valid, code, last,
        input  take, free
    );

    modport row (
        input  valid, code, last,
        output take, free
    );

endinterface

`default_nettype wire

//--- hw/ogbcsr_pkg.sv
// OGBCSR decoder shared types
`default_nettype none

package ogbcsr_pkg;

    // --------------------------------------------------
    // field widths
    // --------------------------------------------------
    localparam int MASK_W    = 4;
    localparam int ROW_CNT_W = 6;
    localparam int TA_CNT_W  = 3;
    localparam int CCL_IDX_W = 5;

    typedef logic [MASK_W-1:0]    block_mask_t;
    typedef logic [ROW_CNT_W-1:0] row_cnt_t;
    typedef logic [TA_CNT_W-1:0]  ta_cnt_t;
    typedef logic [CCL_IDX_W-1:0] ccl_idx_t;

    // position of the set bit in flight
    typedef enum logic [1:0] {
        CODE_BIT0 = 2'd0,
        CODE_BIT1 = 2'd1,
        CODE_BIT2 = 2'd2,
        CODE_BIT3 = 2'd3
    } block_code_t;

    typedef enum logic {
        SPAD_0 = 1'b0,
        SPAD_1 = 1'b1
    } spad_sel_t;

endpackage

`default_nettype wire
